// ==== rtl/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

////////////////////////////////////////
// Data path
////////////////////////////////////////

// Width of one data word
`define RV_XLEN 32

////////////////////////////////////////
// Register file geometry
////////////////////////////////////////

`define RV_REG_AW   5
`define RV_NUM_REGS 32

`endif

// ==== rtl/rv_pkg.sv ====
`include "rv_macros.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]   word_t;
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;

    // ALU operations, pass-B serves lui
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // Decode to execute
    typedef struct packed {
        alu_op_e   alu_op;
        word_t     operand_a;
        word_t     operand_b;
        reg_addr_t rd;
        logic      wen;
    } dec_pkt_t;

    // Execute to writeback
    typedef struct packed {
        reg_addr_t rd;
        word_t     data;
        logic      wen;
    } wb_pkt_t;

endpackage

// ==== rtl/byp_if.sv ====
`timescale 1ns/1ps

// Result a later stage offers back to decode
interface byp_if;

    logic              valid;
    logic              wen;
    rv_pkg::reg_addr_t rd;
    rv_pkg::word_t     data;

    modport source (
        output valid, wen, rd, data
    );

    modport sink (
        input valid, wen, rd, data
    );

endinterface

// ==== rtl/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    payload_t data_q;

    // Free when empty or when the held item leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_data = data_q;

endmodule

// ==== rtl/regfile.sv ====
`timescale 1ns/1ps

`include "rv_macros.svh"

module regfile (
    input  logic              clk,
    input  logic              arst_n,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data,
    byp_if.sink               wb,
    input  logic              wb_fire
);

    rv_pkg::word_t regs [`RV_NUM_REGS];

    // x0 is never written, so it stays zero from reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_fire && wb.wen && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps

`include "rv_macros.svh"

module decode_stage (
    input  rv_pkg::word_t     instr,
    output rv_pkg::reg_addr_t rs1_addr,
    output rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    byp_if.sink               x_byp,
    byp_if.sink               wb_byp,
    output rv_pkg::dec_pkt_t  pkt
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    logic          f7_zero;
    logic          f7_alt;
    logic          legal;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_u;
    rv_pkg::word_t rs1_val;
    rv_pkg::word_t rs2_val;
    logic          x_ok;
    logic          wb_ok;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign f7_zero  = (funct7 == 7'b0000000);
    assign f7_alt   = (funct7 == 7'b0100000);

    assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};

    ////////////////////////////////////////
    // Forwarding, younger producer wins
    ////////////////////////////////////////

    assign x_ok  = x_byp.valid && x_byp.wen && (x_byp.rd != '0);
    assign wb_ok = wb_byp.valid && wb_byp.wen && (wb_byp.rd != '0);

    assign rs1_val = (x_ok && (x_byp.rd == rs1_addr))   ? x_byp.data  :
                     (wb_ok && (wb_byp.rd == rs1_addr)) ? wb_byp.data : rs1_data;
    assign rs2_val = (x_ok && (x_byp.rd == rs2_addr))   ? x_byp.data  :
                     (wb_ok && (wb_byp.rd == rs2_addr)) ? wb_byp.data : rs2_data;

    ////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////

    always_comb begin
        pkt.operand_a = rs1_val;
        pkt.operand_b = (opcode == OPC_OP) ? rs2_val : imm_i;

        case (funct3)
            3'b000:  pkt.alu_op = (opcode == OPC_OP && funct7[5]) ? rv_pkg::ALU_SUB
                                                                  : rv_pkg::ALU_ADD;
            3'b001:  pkt.alu_op = rv_pkg::ALU_SLL;
            3'b010:  pkt.alu_op = rv_pkg::ALU_SLT;
            3'b011:  pkt.alu_op = rv_pkg::ALU_SLTU;
            3'b100:  pkt.alu_op = rv_pkg::ALU_XOR;
            3'b101:  pkt.alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  pkt.alu_op = rv_pkg::ALU_OR;
            default: pkt.alu_op = rv_pkg::ALU_AND;
        endcase

        // funct7 only matters for sub, sra and the immediate shifts
        case (opcode)
            OPC_OP:     legal = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
            OPC_OP_IMM: legal = (funct3 == 3'b001) ? f7_zero :
                                (funct3 == 3'b101) ? (f7_zero || f7_alt) : 1'b1;
            OPC_LUI:    legal = 1'b1;
            default:    legal = 1'b0;
        endcase

        if (opcode == OPC_LUI) begin
            pkt.alu_op    = rv_pkg::ALU_PASS_B;
            pkt.operand_b = imm_u;
        end

        // Unsupported encodings retire as a harmless rd 0 record
        pkt.rd  = legal ? instr[11:7] : '0;
        pkt.wen = legal;
    end

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  rv_pkg::dec_pkt_t pkt,
    input  logic             pkt_valid,
    byp_if.source            x_byp,
    output rv_pkg::wb_pkt_t  wb_pkt
);

    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t result;
    logic [4:0]    shamt;

    assign a     = pkt.operand_a;
    assign b     = pkt.operand_b;
    assign shamt = b[4:0];

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    always_comb begin
        case (pkt.alu_op)
            rv_pkg::ALU_ADD:    result = a + b;
            rv_pkg::ALU_SUB:    result = a - b;
            rv_pkg::ALU_SLL:    result = a << shamt;
            rv_pkg::ALU_SLT:    result = rv_pkg::word_t'($signed(a) < $signed(b));
            rv_pkg::ALU_SLTU:   result = rv_pkg::word_t'(a < b);
            rv_pkg::ALU_XOR:    result = a ^ b;
            rv_pkg::ALU_SRL:    result = a >> shamt;
            rv_pkg::ALU_SRA:    result = $signed(a) >>> shamt;
            rv_pkg::ALU_OR:     result = a | b;
            rv_pkg::ALU_AND:    result = a & b;
            rv_pkg::ALU_PASS_B: result = b;
            default:            result = '0;
        endcase
    end

    // Writeback packet, no data without a write
    assign wb_pkt.rd   = pkt.rd;
    assign wb_pkt.wen  = pkt.wen;
    assign wb_pkt.data = pkt.wen ? result : '0;

    // Same value offered to decode this cycle
    assign x_byp.valid = pkt_valid;
    assign x_byp.wen   = pkt.wen;
    assign x_byp.rd    = pkt.rd;
    assign x_byp.data  = wb_pkt.data;

endmodule

// ==== rtl/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              instr_valid,
    output logic              instr_ready,
    input  rv_pkg::word_t     instr,
    output logic              retire_valid,
    input  logic              retire_ready,
    output rv_pkg::reg_addr_t retire_rd,
    output rv_pkg::word_t     retire_data
);

    rv_pkg::reg_addr_t rs1_addr;
    rv_pkg::reg_addr_t rs2_addr;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;
    rv_pkg::dec_pkt_t  dec_pkt;
    rv_pkg::dec_pkt_t  id_x_pkt;
    rv_pkg::wb_pkt_t   x_pkt;
    rv_pkg::wb_pkt_t   x_wb_pkt;
    logic              id_x_valid;
    logic              x_wb_ready;
    logic              wb_fire;

    byp_if x_byp ();
    byp_if wb_byp ();

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////

    regfile u_regfile (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb_byp),
        .wb_fire  (wb_fire)
    );

    decode_stage u_decode (
        .instr    (instr),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .x_byp    (x_byp),
        .wb_byp   (wb_byp),
        .pkt      (dec_pkt)
    );

    pipe_reg #(.payload_t(rv_pkg::dec_pkt_t)) id_x (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (instr_valid),
        .in_ready  (instr_ready),
        .in_data   (dec_pkt),
        .out_valid (id_x_valid),
        .out_ready (x_wb_ready),
        .out_data  (id_x_pkt)
    );

    ////////////////////////////////////////
    // Execute
    ////////////////////////////////////////

    execute_stage u_execute (
        .pkt       (id_x_pkt),
        .pkt_valid (id_x_valid),
        .x_byp     (x_byp),
        .wb_pkt    (x_pkt)
    );

    pipe_reg #(.payload_t(rv_pkg::wb_pkt_t)) x_wb (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (id_x_valid),
        .in_ready  (x_wb_ready),
        .in_data   (x_pkt),
        .out_valid (retire_valid),
        .out_ready (retire_ready),
        .out_data  (x_wb_pkt)
    );

    ////////////////////////////////////////
    // Writeback and retire
    ////////////////////////////////////////

    assign wb_fire     = retire_valid && retire_ready;
    assign retire_rd   = x_wb_pkt.rd;
    assign retire_data = x_wb_pkt.data;

    assign wb_byp.valid = retire_valid;
    assign wb_byp.wen   = x_wb_pkt.wen;
    assign wb_byp.rd    = x_wb_pkt.rd;
    assign wb_byp.data  = x_wb_pkt.data;

endmodule

// ==== dv/rv_core_assert.sv ====
`timescale 1ns/1ps

module rv_core_assert (
    input logic              clk,
    input logic              arst_n,
    input logic              instr_ready,
    input logic              id_x_valid,
    input logic              retire_valid,
    input logic              retire_ready,
    input rv_pkg::reg_addr_t retire_rd,
    input rv_pkg::word_t     retire_data
);

    // Number of failed assertions
    int unsigned fail_count = 0;

    retire_idle_in_reset: assert property (@(posedge clk) !arst_n |-> !retire_valid)
        else begin
            $error("retire_valid is high while reset is asserted");
            fail_count++;
        end

    // Stalled retire record must not change
    retire_held: assert property (@(posedge clk) disable iff (!arst_n)
        retire_valid && !retire_ready |=>
            retire_valid && $stable(retire_rd) && $stable(retire_data))
        else begin
            $error("retire record changed or dropped while stalled");
            fail_count++;
        end

    // Accepts when empty, and stalls only with both stages full and retire blocked
    ready_follows_fill: assert property (@(posedge clk) disable iff (!arst_n)
        instr_ready == (!id_x_valid || !retire_valid || retire_ready))
        else begin
            $error("instr_ready does not match how full the pipeline is");
            fail_count++;
        end

endmodule

bind rv_core_top rv_core_assert u_assert (
    .clk          (clk),
    .arst_n       (arst_n),
    .instr_ready  (instr_ready),
    .id_x_valid   (id_x_valid),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
);

// ==== dv/rv_checker.sv ====
`timescale 1ns/1ps

module rv_checker #(
    parameter int N = 1
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              retire_valid,
    input  logic              retire_ready,
    input  rv_pkg::reg_addr_t retire_rd,
    input  rv_pkg::word_t     retire_data,
    input  rv_pkg::reg_addr_t exp_rd   [N],
    input  rv_pkg::word_t     exp_data [N],
    output logic              done,
    output int unsigned       checked,
    output int unsigned       mismatches,
    output int unsigned       extras
);

    initial begin
        checked    = 0;
        mismatches = 0;
        extras     = 0;
    end

    assign done = (checked == N);

    ////////////////////////////////////////
    // One table entry per retire handshake
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (arst_n && retire_valid && retire_ready) begin
            if (checked >= N) begin
                extras++;
                $display("Unexpected retire record after all %0d entries (rd %0d)",
                         N, retire_rd);
            end else begin
                if (retire_rd !== exp_rd[checked]) begin
                    mismatches++;
                    $display("FAIL retire_rd at entry %0d: got %h, expected %h",
                             checked, retire_rd, exp_rd[checked]);
                end
                if (retire_data !== exp_data[checked]) begin
                    mismatches++;
                    $display("FAIL retire_data at entry %0d: got %h, expected %h",
                             checked, retire_data, exp_data[checked]);
                end
                checked++;
            end
        end
    end

endmodule

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

    localparam int N_VEC       = 26;
    localparam int CYCLE_LIMIT = 4 + 6 * N_VEC + 50;

    logic              clk;
    logic              arst_n;
    logic              instr_valid;
    logic              instr_ready;
    rv_pkg::word_t     instr;
    logic              retire_valid;
    logic              retire_ready;
    rv_pkg::reg_addr_t retire_rd;
    rv_pkg::word_t     retire_data;

    rv_pkg::word_t     instr_tbl [N_VEC];
    rv_pkg::reg_addr_t exp_rd    [N_VEC];
    rv_pkg::word_t     exp_data  [N_VEC];

    logic        all_retired;
    int unsigned n_checked;
    int unsigned n_mismatch;
    int unsigned n_extra;
    int unsigned n_assert;
    int unsigned cycles = 0;
    int          next_idx;
    logic        fired;

    rv_core_top dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .instr        (instr),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    rv_checker #(.N(N_VEC)) u_checker (
        .clk          (clk),
        .arst_n       (arst_n),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .exp_rd       (exp_rd),
        .exp_data     (exp_data),
        .done         (all_retired),
        .checked      (n_checked),
        .mismatches   (n_mismatch),
        .extras       (n_extra)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////

    function automatic rv_pkg::word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic rv_pkg::word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic rv_pkg::word_t u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic set_entry(input int i, input rv_pkg::word_t w, input logic [4:0] rd,
                             input rv_pkg::word_t data);
        instr_tbl[i] = w;
        exp_rd[i]    = rd;
        exp_data[i]  = data;
    endtask

    // x1 = 5 and x2 = -3 feed most of the later entries
    task automatic load_table();
        set_entry(0,  i_type(12'd5, 5'd0, 3'b000, 5'd1), 5'd1, 32'h0000_0005);
        set_entry(1,  i_type(12'hffd, 5'd0, 3'b000, 5'd2), 5'd2, 32'hffff_fffd);
        set_entry(2,  r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, 32'h0000_0002);
        set_entry(3,  r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 5'd4, 32'h0000_0008);
        set_entry(4,  r_type(7'h20, 5'd1, 5'd0, 3'b000, 5'd5), 5'd5, 32'hffff_fffb);
        set_entry(5,  r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd6), 5'd6, 32'h0000_0001);
        set_entry(6,  r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd7), 5'd7, 32'h0000_0000);
        set_entry(7,  u_type(20'h80000, 5'd8), 5'd8, 32'h8000_0000);
        set_entry(8,  i_type(12'h404, 5'd8, 3'b101, 5'd9), 5'd9, 32'hf800_0000);
        set_entry(9,  i_type(12'h004, 5'd8, 3'b101, 5'd10), 5'd10, 32'h0800_0000);
        set_entry(10, r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd11), 5'd11, 32'hffff_fff8);
        set_entry(11, r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd12), 5'd12, 32'hffff_fffd);
        set_entry(12, r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd13), 5'd13, 32'h0000_0005);
        set_entry(13, r_type(7'h00, 5'd1, 5'd1, 3'b001, 5'd14), 5'd14, 32'h0000_00a0);
        set_entry(14, r_type(7'h20, 5'd1, 5'd2, 3'b101, 5'd15), 5'd15, 32'hffff_ffff);
        set_entry(15, r_type(7'h00, 5'd1, 5'd2, 3'b101, 5'd16), 5'd16, 32'h07ff_ffff);
        // x0 write retires its data, the next read still sees zero
        set_entry(16, i_type(12'd7, 5'd1, 3'b000, 5'd0), 5'd0, 32'h0000_000c);
        set_entry(17, r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd17), 5'd17, 32'h0000_0005);
        set_entry(18, i_type(12'hfff, 5'd2, 3'b010, 5'd18), 5'd18, 32'h0000_0001);
        set_entry(19, i_type(12'hfff, 5'd1, 3'b011, 5'd19), 5'd19, 32'h0000_0001);
        set_entry(20, i_type(12'hfff, 5'd1, 3'b100, 5'd20), 5'd20, 32'hffff_fffa);
        set_entry(21, i_type(12'h0f0, 5'd2, 3'b111, 5'd21), 5'd21, 32'h0000_00f0);
        // lw x1, 0(x2) is not supported and must leave x1 alone
        set_entry(22, 32'h0001_2083, 5'd0, 32'h0000_0000);
        set_entry(23, r_type(7'h00, 5'd0, 5'd1, 3'b000, 5'd22), 5'd22, 32'h0000_0005);
        set_entry(24, i_type(12'h01f, 5'd1, 3'b001, 5'd23), 5'd23, 32'h8000_0000);
        set_entry(25, r_type(7'h20, 5'd1, 5'd23, 3'b000, 5'd24), 5'd24, 32'h7fff_fffb);
    endtask

    ////////////////////////////////////////
    // Driver
    ////////////////////////////////////////

    initial begin
        void'($urandom(53));
        arst_n       = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        retire_ready = 1'b0;
        load_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n   = 1'b1;
        next_idx = 0;

        while (!all_retired) begin
            @(posedge clk);
            fired = instr_valid && instr_ready;
            if (fired) begin
                next_idx++;
            end
            @(negedge clk);
            retire_ready = ($urandom_range(3) != 0);
            // A raised valid holds until its handshake
            if (!instr_valid || fired) begin
                if (next_idx < N_VEC && $urandom_range(3) != 0) begin
                    instr_valid = 1'b1;
                    instr       = instr_tbl[next_idx];
                end else begin
                    instr_valid = 1'b0;
                end
            end
        end

        instr_valid  = 1'b0;
        retire_ready = 1'b1;
        repeat (4) @(negedge clk);
        n_assert = dut.u_assert.fail_count;
        $display("Retired %0d of %0d, mismatches %0d, extra records %0d, assertion failures %0d",
                 n_checked, N_VEC, n_mismatch, n_extra, n_assert);
        if (n_mismatch == 0 && n_extra == 0 && n_assert == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run hung: only %0d of %0d records retired within %0d cycles",
                     n_checked, N_VEC, CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/rv_pkg.sv
rtl/byp_if.sv
rtl/pipe_reg.sv
rtl/regfile.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/rv_core_top.sv
dv/rv_core_assert.sv
dv/rv_checker.sv
dv/tb_top.sv
